//--- verilog/guess_pkg.sv
package guess_pkg;

	// ********************
	// Widths
	// ********************
	localparam int DIGIT_W    = 4;
	localparam int SEG_W      = 8;   // Bit 7 is the decimal point
	localparam int NUM_DIGITS = 4;

	// ********************
	// Types
	// ********************
	typedef enum logic [2:0] {
		v_none = 3'd0,   // No guess since restart
		v_low  = 3'd1,
		v_high = 3'd2,
		v_win  = 3'd3,
		v_lost = 3'd4
	} verdict_e;

	typedef enum logic {
		cfg_secret    = 1'b0,
		cfg_max_tries = 1'b1
	} cfg_sel_e;

	// ********************
	// Segment codes, active high
	// ********************
	localparam logic [SEG_W-1:0] seg_digit_codes [10] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
		8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
	};

	localparam logic [SEG_W-1:0] seg_blank = 8'h00;
	localparam logic [SEG_W-1:0] seg_dash  = 8'h40;
	localparam logic [SEG_W-1:0] seg_l     = 8'h38;
	localparam logic [SEG_W-1:0] seg_h     = 8'h76;
	localparam logic [SEG_W-1:0] seg_eq    = 8'h48;
	localparam logic [SEG_W-1:0] seg_f     = 8'h71;

endpackage

//--- verilog/guess_status_if.sv
`timescale 1ns/10ps

interface guess_status_if;

	logic [guess_pkg::DIGIT_W-1:0] guess;   // Last accepted guess
	logic [guess_pkg::DIGIT_W-1:0] tries;
	guess_pkg::verdict_e           verdict;
	logic                          game_over;

	modport judge (
		output guess,
		output tries,
		output verdict,
		output game_over
	);

	modport display (
		input guess,
		input tries,
		input verdict,
		input game_over
	);

endinterface

//--- verilog/game_config_regs.sv
`timescale 1ns/10ps

module game_config_regs
(
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          cfg_we,
	input  guess_pkg::cfg_sel_e           cfg_sel,
	input  logic [guess_pkg::DIGIT_W-1:0] cfg_wdata,
	output logic [guess_pkg::DIGIT_W-1:0] secret,
	output logic [guess_pkg::DIGIT_W-1:0] max_tries
);

	logic secret_ok;
	logic tries_ok;

	assign secret_ok = (cfg_wdata <= 4'd9);
	assign tries_ok  = (cfg_wdata != 4'd0) && (cfg_wdata <= 4'd9);

	// ********************
	// Register writes
	// ********************
	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			secret    <= 4'd0;
			max_tries <= 4'd3;
		end
		else if (cfg_we)
		begin
			case (cfg_sel)
			guess_pkg::cfg_secret:
			begin
				if (secret_ok)
					secret <= cfg_wdata;
			end
			guess_pkg::cfg_max_tries:
			begin
				if (tries_ok)
					max_tries <= cfg_wdata;   // Zero would end the game before it starts
			end
			endcase
		end
	end

	a_max_tries_nonzero: assert property (
		@(posedge CLK) disable iff (!rst_n) max_tries != 4'd0
	) else $error("max_tries became zero");

endmodule

//--- verilog/guess_judge.sv
`timescale 1ns/10ps

module guess_judge
(
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          guess_stb,
	input  logic [guess_pkg::DIGIT_W-1:0] guess_val,
	input  logic                          restart,
	input  logic [guess_pkg::DIGIT_W-1:0] secret,
	input  logic [guess_pkg::DIGIT_W-1:0] max_tries,
	guess_status_if.judge                 status
);

	logic                          accept;
	logic [guess_pkg::DIGIT_W-1:0] tries_next;
	guess_pkg::verdict_e           verdict_next;
	logic                          over_next;

	// Running game and a legal digit
	assign accept     = guess_stb && !status.game_over && (guess_val <= 4'd9);
	assign tries_next = status.tries + 4'd1;

	// ********************
	// Verdict decision
	// ********************
	always_comb
	begin
		if (guess_val == secret)
			verdict_next = guess_pkg::v_win;
		else if (tries_next >= max_tries)
			verdict_next = guess_pkg::v_lost;
		else if (guess_val < secret)
			verdict_next = guess_pkg::v_low;
		else
			verdict_next = guess_pkg::v_high;
	end

	assign over_next = (verdict_next == guess_pkg::v_win) ||
			(verdict_next == guess_pkg::v_lost);

	// ********************
	// Status registers
	// ********************
	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			status.guess     <= 4'd0;
			status.tries     <= 4'd0;
			status.verdict   <= guess_pkg::v_none;
			status.game_over <= 1'b0;
		end
		else if (restart)   // Beats a guess in the same cycle
		begin
			status.guess     <= 4'd0;
			status.tries     <= 4'd0;
			status.verdict   <= guess_pkg::v_none;
			status.game_over <= 1'b0;
		end
		else if (accept)
		begin
			status.guess     <= guess_val;
			status.tries     <= tries_next;
			status.verdict   <= verdict_next;
			status.game_over <= over_next;
		end
	end

	a_tries_max: assert property (
		@(posedge CLK) disable iff (!rst_n) status.tries <= 4'd9
	) else $error("tries above 9");

	a_over_matches_verdict: assert property (
		@(posedge CLK) disable iff (!rst_n)
		status.game_over == ((status.verdict == guess_pkg::v_win) ||
				(status.verdict == guess_pkg::v_lost))
	) else $error("game_over out of step with verdict");

endmodule

//--- verilog/digit_scan_display.sv
`timescale 1ns/10ps

module digit_scan_display
#(
	parameter int SCAN_TICKS = 50000
)
(
	input  logic                             CLK,
	input  logic                             rst_n,
	guess_status_if.display                  status,
	output logic [guess_pkg::SEG_W-1:0]      seg,
	output logic [guess_pkg::NUM_DIGITS-1:0] digit_sel
);

	localparam int CNT_W = (SCAN_TICKS > 1) ? $clog2(SCAN_TICKS) : 1;

	logic [CNT_W-1:0]              scan_cnt;
	logic                          scan_tick;
	logic [guess_pkg::SEG_W-1:0]   verdict_seg;

	function automatic logic [guess_pkg::SEG_W-1:0] digit_code(
		input logic [guess_pkg::DIGIT_W-1:0] d
	);
		if (d <= 4'd9)
			digit_code = guess_pkg::seg_digit_codes[d];
		else
			digit_code = guess_pkg::seg_blank;
	endfunction

	// ********************
	// Scan timer
	// ********************
	assign scan_tick = (scan_cnt == CNT_W'(SCAN_TICKS - 1));

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scan_cnt  <= '0;
			digit_sel <= 4'b1110;
		end
		else if (scan_tick)
		begin
			scan_cnt  <= '0;
			digit_sel <= {digit_sel[2:0], digit_sel[3]};   // Rotate left
		end
		else
		begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// ********************
	// Segment decode
	// ********************
	always_comb
	begin
		if (status.game_over)
			verdict_seg = (status.verdict == guess_pkg::v_win) ? guess_pkg::seg_eq
					: guess_pkg::seg_f;
		else
		begin
			case (status.verdict)
			guess_pkg::v_low:  verdict_seg = guess_pkg::seg_l;
			guess_pkg::v_high: verdict_seg = guess_pkg::seg_h;
			default:           verdict_seg = guess_pkg::seg_dash;
			endcase
		end
	end

	always_comb
	begin
		case (digit_sel)
		4'b1110: seg = digit_code(status.guess);
		4'b1101: seg = guess_pkg::seg_blank;
		4'b1011: seg = verdict_seg;
		4'b0111: seg = digit_code(status.tries);
		default: seg = guess_pkg::seg_blank;
		endcase
	end

	a_one_digit_active: assert property (
		@(posedge CLK) disable iff (!rst_n) $onehot(~digit_sel)
	) else $error("digit_sel not one-hot low");

endmodule

//--- verilog/guess_game_top.sv
`timescale 1ns/10ps

module guess_game_top
#(
	parameter int SCAN_TICKS = 50000
)
(
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       cfg_we,
	input  logic       cfg_sel,
	input  logic [3:0] cfg_wdata,
	input  logic       guess_stb,
	input  logic [3:0] guess_val,
	input  logic       restart,
	output logic [7:0] seg,
	output logic [3:0] digit_sel,
	output logic       game_over
);

	logic [guess_pkg::DIGIT_W-1:0] secret;
	logic [guess_pkg::DIGIT_W-1:0] max_tries;

	guess_status_if status_if ();

	game_config_regs u_cfg (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_sel   (guess_pkg::cfg_sel_e'(cfg_sel)),
		.cfg_wdata (cfg_wdata),
		.secret    (secret),
		.max_tries (max_tries)
	);

	guess_judge u_judge (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.guess_stb (guess_stb),
		.guess_val (guess_val),
		.restart   (restart),
		.secret    (secret),
		.max_tries (max_tries),
		.status    (status_if.judge)
	);

	digit_scan_display #(.SCAN_TICKS(SCAN_TICKS)) u_disp (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.status    (status_if.display),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

	assign game_over = status_if.game_over;

endmodule

//--- verif/guess_game_tb.sv
`timescale 1ns/10ps

module guess_game_tb;

	typedef enum logic [2:0] {m_none, m_low, m_high, m_win, m_lost} model_verdict_e;

	logic       CLK = 1'b0;
	logic       rst_n = 1'b0;
	logic       cfg_we = 1'b0;
	logic       cfg_sel = 1'b0;
	logic [3:0] cfg_wdata = 4'd0;
	logic       guess_stb = 1'b0;
	logic [3:0] guess_val = 4'd0;
	logic       restart = 1'b0;
	logic [7:0] seg;
	logic [3:0] digit_sel;
	logic       game_over;

	logic [3:0]     m_secret;
	logic [3:0]     m_max;
	logic [3:0]     m_guess;
	logic [3:0]     m_tries;
	logic [3:0]     m_sel;
	logic [1:0]     m_cnt;
	model_verdict_e m_verdict;
	logic           m_over;
	logic [7:0]     exp_seg;
	logic [3:0]     secret;

	guess_game_top #(.SCAN_TICKS(3)) dut (
		.CLK(CLK), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
		.guess_stb(guess_stb), .guess_val(guess_val), .restart(restart),
		.seg(seg), .digit_sel(digit_sel), .game_over(game_over)
	);

	always #20 CLK = ~CLK;

	function automatic logic [7:0] digit_pattern(input logic [3:0] d);
		case (d)
		4'd0: digit_pattern = 8'h3f;
		4'd1: digit_pattern = 8'h06;
		4'd2: digit_pattern = 8'h5b;
		4'd3: digit_pattern = 8'h4f;
		4'd4: digit_pattern = 8'h66;
		4'd5: digit_pattern = 8'h6d;
		4'd6: digit_pattern = 8'h7d;
		4'd7: digit_pattern = 8'h07;
		4'd8: digit_pattern = 8'h7f;
		4'd9: digit_pattern = 8'h6f;
		default: digit_pattern = 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] verdict_pattern(input model_verdict_e v);
		case (v)
		m_low:   verdict_pattern = 8'h38;
		m_high:  verdict_pattern = 8'h76;
		m_win:   verdict_pattern = 8'h48;
		m_lost:  verdict_pattern = 8'h71;
		default: verdict_pattern = 8'h40;   // Dash before the first guess
		endcase
	endfunction

	// ********************
	// Reference model
	// ********************
	always @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m_secret <= 4'd0;
			m_max <= 4'd3;
			m_guess <= 4'd0;
			m_tries <= 4'd0;
			m_verdict <= m_none;
			m_over <= 1'b0;
			m_sel <= 4'b1110;
			m_cnt <= 2'd0;
		end
		else
		begin
			if (cfg_we && !cfg_sel && cfg_wdata <= 4'd9)
				m_secret <= cfg_wdata;
			if (cfg_we && cfg_sel && cfg_wdata != 4'd0 && cfg_wdata <= 4'd9)
				m_max <= cfg_wdata;
			if (restart)
			begin
				m_guess <= 4'd0;
				m_tries <= 4'd0;
				m_verdict <= m_none;
				m_over <= 1'b0;
			end
			else if (guess_stb && !m_over && guess_val <= 4'd9)
			begin
				m_guess <= guess_val;
				m_tries <= m_tries + 4'd1;
				m_over  <= (guess_val == m_secret) || (m_tries + 4'd1 == m_max);
				if (guess_val == m_secret)
					m_verdict <= m_win;
				else if (m_tries + 4'd1 == m_max)
					m_verdict <= m_lost;
				else if (guess_val < m_secret)
					m_verdict <= m_low;
				else
					m_verdict <= m_high;
			end
			m_cnt <= (m_cnt == 2'd2) ? 2'd0 : m_cnt + 2'd1;
			if (m_cnt == 2'd2)
				m_sel <= {m_sel[2:0], m_sel[3]};
		end
	end

	always_comb
	begin
		case (m_sel)
		4'b1110: exp_seg = digit_pattern(m_guess);
		4'b1011: exp_seg = verdict_pattern(m_verdict);
		4'b0111: exp_seg = digit_pattern(m_tries);
		default: exp_seg = 8'h00;
		endcase
	end

	// ********************
	// Checks
	// ********************
	a_sel: assert property (@(posedge CLK) disable iff (!rst_n) digit_sel == m_sel)
	else
	begin
		$display("Mismatch at %0t: digit_sel %b, expected %b", $time, $sampled(digit_sel),
				$sampled(m_sel));
		$display("TEST FAIL");
		$fatal(1, "digit select out of order");
	end

	a_one_low: assert property (@(posedge CLK) disable iff (!rst_n) $onehot(~digit_sel))
	else
	begin
		$display("Mismatch at %0t: digit_sel %b has not one low bit", $time,
				$sampled(digit_sel));
		$display("TEST FAIL");
		$fatal(1, "digit select not one-hot low");
	end

	a_seg: assert property (@(posedge CLK) disable iff (!rst_n) seg == exp_seg)
	else
	begin
		$display("Mismatch at %0t: seg %h, expected %h", $time, $sampled(seg),
				$sampled(exp_seg));
		$display("TEST FAIL");
		$fatal(1, "segment pattern wrong");
	end

	a_over: assert property (@(posedge CLK) disable iff (!rst_n) game_over == m_over)
	else
	begin
		$display("Mismatch at %0t: game_over %b, expected %b", $time, $sampled(game_over),
				$sampled(m_over));
		$display("TEST FAIL");
		$fatal(1, "game_over wrong");
	end

	// ********************
	// Stimulus
	// ********************
	task automatic write_cfg(input logic sel, input logic [3:0] data);
		cfg_we = 1'b1;
		cfg_sel = sel;
		cfg_wdata = data;
		@(posedge CLK);
		#2 cfg_we = 1'b0;
	endtask

	task automatic send_guess(input logic [3:0] value, input logic with_restart);
		guess_stb = 1'b1;
		guess_val = value;
		restart = with_restart;
		@(posedge CLK);
		#2 guess_stb = 1'b0;
		restart = 1'b0;
	endtask

	task automatic scan_all_digits;   // Lets every position pass the segment check
		logic [3:0] seen;
		int         n;
		seen = 4'd0;
		n = 0;
		while (seen != 4'hf)
		begin
			@(posedge CLK);
			#2 seen = seen | ~digit_sel;
			n++;
			if (n > 20)
			begin
				$display("TEST FAIL");
				$fatal(1, "Display scan did not visit all four digits");
			end
		end
		@(posedge CLK);   // Last position reached is checked at this edge
		#2;
	endtask

	task automatic wait_game_over(input logic level);
		int n;
		n = 0;
		while (game_over !== level)
		begin
			@(posedge CLK);
			#2 n++;
			if (n > 10)
			begin
				$display("TEST FAIL");
				$fatal(1, "game_over never reached the expected level");
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'hf496cad0));
		repeat (3) @(posedge CLK);
		#2 rst_n = 1'b1;
		scan_all_digits();
		secret = 4'd1 + 4'($urandom % 8);
		write_cfg(1'b0, secret);
		write_cfg(1'b1, 4'd9);
		write_cfg(1'b0, 4'd12);   // Rejected values
		write_cfg(1'b1, 4'd0);
		send_guess(4'd11, 1'b0);
		scan_all_digits();
		repeat (5)
		begin
			send_guess(4'((secret + 4'd1 + 4'($urandom % 9)) % 10), 1'b0);
			scan_all_digits();
		end
		send_guess(secret, 1'b0);
		wait_game_over(1'b1);
		send_guess(4'((secret + 4'd1) % 10), 1'b0);
		scan_all_digits();
		send_guess(secret, 1'b1);   // Restart after a win
		wait_game_over(1'b0);
		scan_all_digits();
		send_guess(secret, 1'b1);   // Running game, restart wins over the winning guess
		scan_all_digits();
		write_cfg(1'b1, 4'd2);
		send_guess(4'((secret + 4'd3) % 10), 1'b0);
		scan_all_digits();
		send_guess(4'((secret + 4'd4) % 10), 1'b0);
		wait_game_over(1'b1);
		send_guess(secret, 1'b0);
		scan_all_digits();
		send_guess(4'd0, 1'b1);
		wait_game_over(1'b0);
		scan_all_digits();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- src.f
verilog/guess_pkg.sv
verilog/guess_status_if.sv
verilog/game_config_regs.sv
verilog/guess_judge.sv
verilog/digit_scan_display.sv
verilog/guess_game_top.sv
verif/guess_game_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = guess_game_tb
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
